//--- common/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// datapath widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// l1 data cache geometry, one word per line
`define LSU_L1D_IDX_W 2
`define LSU_L1D_LINES 4

// cacheable windows, each one half-open [lo, hi)
`define LSU_CACHE_R0_LO 32'h3000_0000
`define LSU_CACHE_R0_HI 32'h4000_0000

// main memory window
`define LSU_CACHE_R1_LO 32'h8000_0000
`define LSU_CACHE_R1_HI 32'h8040_0000

`define LSU_CACHE_R2_LO 32'hA000_0000
`define LSU_CACHE_R2_HI 32'hC000_0000

`endif

//--- common/lsu_op_pkg.sv
`include "lsu_consts.svh"

package lsu_op_pkg;

  // memory operation code from the core
  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_LB  = 4'd1,
    OP_LH  = 4'd2,
    OP_LW  = 4'd3,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_SB  = 4'd6,
    OP_SH  = 4'd7,
    OP_SW  = 4'd8
  } lsu_op_e;

  // access size
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } lsu_size_e;

  // request as handed over by the core
  typedef struct packed {
    lsu_op_e                 op;
    logic [`LSU_ADDR_W-1:0]  addr;
    logic [`LSU_DATA_W-1:0]  wdata;
  } lsu_req_t;

  // decoded control, shared by all later stages
  typedef struct packed {
    logic       is_load;
    logic       is_store;
    lsu_size_e  size;
    logic       sign_ext;
    logic [3:0] strb;
  } lsu_ctl_t;

endpackage

//--- common/lsu_bus_pkg.sv
`include "lsu_consts.svh"

package lsu_bus_pkg;

  // read port request
  // the memory always returns the full aligned word
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic [3:0]             strb;
  } rd_req_t;

  // write port request
  // data is not shifted, strobe sits in the low bits
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
    logic [3:0]             strb;
  } wr_req_t;

endpackage

//--- lsu/lsu_op_decode.sv
`timescale 1ns/1ps

module lsu_op_decode (
  input  logic                 req_valid_i,
  input  lsu_op_pkg::lsu_op_e  op_i,
  output lsu_op_pkg::lsu_ctl_t ctl_o
);

  import lsu_op_pkg::*;

  lsu_size_e  size;
  logic [3:0] strb;
  logic       is_load;
  logic       is_store;
  logic       sign_ext;

  // access size per opcode
  always_comb
  begin
    case (op_i)
      OP_LB, OP_LBU, OP_SB: size = SZ_BYTE;
      OP_LH, OP_LHU, OP_SH: size = SZ_HALF;
      default:              size = SZ_WORD;
    endcase
  end

  // byte strobes follow the size
  always_comb
  begin
    case (size)
      SZ_BYTE: strb = 4'h1;
      SZ_HALF: strb = 4'h3;
      default: strb = 4'hf;
    endcase
  end

  assign is_load  = (op_i == OP_LB) || (op_i == OP_LH) || (op_i == OP_LW) ||
                    (op_i == OP_LBU) || (op_i == OP_LHU);
  assign is_store = (op_i == OP_SB) || (op_i == OP_SH) || (op_i == OP_SW);

  // only the signed loads extend the top bit
  assign sign_ext = (op_i == OP_LB) || (op_i == OP_LH);

  // nop or idle core leaves both flags clear
  always_comb
  begin
    ctl_o          = '0;
    ctl_o.size     = size;
    ctl_o.strb     = strb;
    ctl_o.sign_ext = sign_ext;
    if (req_valid_i)
    begin
      ctl_o.is_load  = is_load;
      ctl_o.is_store = is_store;
    end
  end

endmodule

//--- lsu/lsu_access_ctrl.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_access_ctrl (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   issue_i,
  input  logic                   req_valid_i,
  input  logic [`LSU_ADDR_W-1:0] addr_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  lsu_op_pkg::lsu_ctl_t   ctl_i,
  input  logic                   cache_hit_i,
  output logic [`LSU_ADDR_W-1:0] eff_addr_o,
  output lsu_bus_pkg::rd_req_t   rd_req_o,
  output logic                   rd_valid_o,
  output lsu_bus_pkg::wr_req_t   wr_req_o,
  output logic                   wr_valid_o
);

  // address captured at issue
  logic [`LSU_ADDR_W-1:0] addr_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      addr_q <= '0;
    end
    else if (issue_i)
    begin
      addr_q <= addr_i;
    end
  end

  // issue cycle uses the live address, held copy after that
  assign eff_addr_o = issue_i ? addr_i : addr_q;

  // a load that hits in the l1d never reaches the bus
  assign rd_valid_o = req_valid_i & ctl_i.is_load & ~cache_hit_i;

  // stores always go out, the cache is write-through
  assign wr_valid_o = req_valid_i & ctl_i.is_store;

  // read request
  always_comb
  begin
    rd_req_o      = '0;
    rd_req_o.addr = eff_addr_o;
    rd_req_o.strb = ctl_i.strb;
  end

  // write request, data kept as the core gave it
  always_comb
  begin
    wr_req_o      = '0;
    wr_req_o.addr = eff_addr_o;
    wr_req_o.data = wdata_i;
    wr_req_o.strb = ctl_i.strb;
  end

endmodule

//--- lsu/lsu_l1d_cache.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_l1d_cache (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`LSU_ADDR_W-1:0] addr_i,
  input  lsu_op_pkg::lsu_ctl_t   ctl_i,
  input  logic [`LSU_DATA_W-1:0] rd_data_i,
  input  logic                   rd_ack_i,
  input  logic                   wr_valid_i,
  output logic                   hit_o,
  output logic [`LSU_DATA_W-1:0] hit_data_o
);

  localparam int unsigned IDX_LO = 2;
  localparam int unsigned TAG_LO = IDX_LO + `LSU_L1D_IDX_W;
  localparam int unsigned TAG_W  = `LSU_ADDR_W - TAG_LO;

  // line storage
  logic [`LSU_DATA_W-1:0]   data_q [`LSU_L1D_LINES];
  logic [TAG_W-1:0]         tag_q  [`LSU_L1D_LINES];
  logic [`LSU_L1D_LINES-1:0] valid_q;

  logic [`LSU_L1D_IDX_W-1:0] idx;
  logic [TAG_W-1:0]          tag;
  logic                      cacheable;
  logic                      tag_match;
  logic                      fill;
  logic                      inval;

  assign idx = addr_i[TAG_LO-1:IDX_LO];
  assign tag = addr_i[`LSU_ADDR_W-1:TAG_LO];

  // cacheable windows
  assign cacheable =
    ((addr_i >= `LSU_CACHE_R0_LO) && (addr_i < `LSU_CACHE_R0_HI)) ||
    ((addr_i >= `LSU_CACHE_R1_LO) && (addr_i < `LSU_CACHE_R1_HI)) ||
    ((addr_i >= `LSU_CACHE_R2_LO) && (addr_i < `LSU_CACHE_R2_HI));

  assign tag_match = valid_q[idx] && (tag_q[idx] == tag);

  // lookup, answered in the same cycle
  assign hit_o      = ctl_i.is_load & cacheable & tag_match;
  assign hit_data_o = data_q[idx];

  // fill on the ack cycle of a cacheable miss
  assign fill = ctl_i.is_load & rd_ack_i & cacheable;

  // store to a cached word drops the line
  assign inval = wr_valid_i & ctl_i.is_store & tag_match;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_q <= '0;
    end
    else if (fill)
    begin
      valid_q[idx] <= 1'b1;
    end
    else if (inval)
    begin
      valid_q[idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      data_q[idx] <= rd_data_i;
      tag_q[idx]  <= tag;
    end
  end

endmodule

//--- lsu/lsu_load_align.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_load_align (
  input  lsu_op_pkg::lsu_ctl_t   ctl_i,
  input  logic [1:0]             byte_off_i,
  input  logic                   hit_i,
  input  logic [`LSU_DATA_W-1:0] hit_data_i,
  input  logic [`LSU_DATA_W-1:0] rd_data_i,
  input  logic                   rd_ack_i,
  input  logic                   wr_ack_i,
  output logic [`LSU_DATA_W-1:0] load_data_o,
  output logic                   done_o
);

  import lsu_op_pkg::*;

  logic [`LSU_DATA_W-1:0] word;
  logic [`LSU_DATA_W-1:0] shifted;
  logic [`LSU_DATA_W-1:0] extended;

  // bus data wins on an ack, the cache line otherwise
  assign word = rd_ack_i ? rd_data_i : hit_data_i;

  // bring the addressed byte down to bit 0
  assign shifted = word >> {byte_off_i, 3'b000};

  always_comb
  begin
    case (ctl_i.size)
      SZ_BYTE: extended = {{24{ctl_i.sign_ext & shifted[7]}}, shifted[7:0]};
      SZ_HALF: extended = {{16{ctl_i.sign_ext & shifted[15]}}, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  // stores return zero
  assign load_data_o = ctl_i.is_load ? extended : '0;

  assign done_o = (ctl_i.is_load & (hit_i | rd_ack_i)) |
                  (ctl_i.is_store & wr_ack_i);

endmodule

//--- lsu/lsu_top.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   issue_i,
  input  logic                   req_valid_i,
  input  lsu_op_pkg::lsu_req_t   req_i,
  output lsu_bus_pkg::rd_req_t   rd_req_o,
  output logic                   rd_valid_o,
  input  logic [`LSU_DATA_W-1:0] rd_data_i,
  input  logic                   rd_ack_i,
  output lsu_bus_pkg::wr_req_t   wr_req_o,
  output logic                   wr_valid_o,
  input  logic                   wr_ack_i,
  output logic [`LSU_DATA_W-1:0] load_data_o,
  output logic                   done_o
);

  import lsu_op_pkg::*;

  lsu_ctl_t               ctl;
  logic [`LSU_ADDR_W-1:0] eff_addr;
  logic                   hit;
  logic [`LSU_DATA_W-1:0] hit_data;

  lsu_op_decode u_decode (
    .req_valid_i (req_valid_i),
    .op_i        (req_i.op),
    .ctl_o       (ctl)
  );

  lsu_access_ctrl u_access (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .issue_i     (issue_i),
    .req_valid_i (req_valid_i),
    .addr_i      (req_i.addr),
    .wdata_i     (req_i.wdata),
    .ctl_i       (ctl),
    .cache_hit_i (hit),
    .eff_addr_o  (eff_addr),
    .rd_req_o    (rd_req_o),
    .rd_valid_o  (rd_valid_o),
    .wr_req_o    (wr_req_o),
    .wr_valid_o  (wr_valid_o)
  );

  // lookup and invalidate both use the effective address
  lsu_l1d_cache u_l1d (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .addr_i     (eff_addr),
    .ctl_i      (ctl),
    .rd_data_i  (rd_data_i),
    .rd_ack_i   (rd_ack_i),
    .wr_valid_i (wr_valid_o),
    .hit_o      (hit),
    .hit_data_o (hit_data)
  );

  lsu_load_align u_align (
    .ctl_i       (ctl),
    .byte_off_i  (eff_addr[1:0]),
    .hit_i       (hit),
    .hit_data_i  (hit_data),
    .rd_data_i   (rd_data_i),
    .rd_ack_i    (rd_ack_i),
    .wr_ack_i    (wr_ack_i),
    .load_data_o (load_data_o),
    .done_o      (done_o)
  );

endmodule

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_tb;

  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  localparam int CLK_HALF      = 2;
  localparam int RESET_CYCLES  = 10;
  // operations issued by all tests together
  localparam int NUM_OPS       = 85;
  // issue, up to three wait edges, ack, release and idle, with margin
  localparam int MAX_OP_CYCLES = 10;
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 1) + NUM_OPS * MAX_OP_CYCLES;

  logic                   clk = 1'b0;
  logic                   rst_n_i;
  logic                   issue_i;
  logic                   req_valid_i;
  lsu_req_t               req_i;
  rd_req_t                rd_req_o;
  logic                   rd_valid_o;
  logic [`LSU_DATA_W-1:0] rd_data_i = '0;
  logic                   rd_ack_i = 1'b0;
  wr_req_t                wr_req_o;
  logic                   wr_valid_o;
  logic                   wr_ack_i = 1'b0;
  logic [`LSU_DATA_W-1:0] load_data_o;
  logic                   done_o;

  // bus side memory and the expected copy, both by word address
  logic [31:0] bus_mem [logic [29:0]];
  logic [31:0] ref_mem [logic [29:0]];

  integer      seed = 32'h3a3ae3fd;
  logic        mem_busy = 1'b0;
  int          mem_wait = 0;
  string       test_name = "reset";
  int          error_count = 0;

  // what the last operation showed on the bus
  logic        saw_rd;
  logic        first_rd_valid;
  logic        first_wr_valid;
  logic [3:0]  seen_rd_strb;
  logic [3:0]  seen_wr_strb;
  logic [31:0] seen_wr_data;
  int          op_cycles;

  always #CLK_HALF clk = ~clk;

  lsu_top dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .issue_i     (issue_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rd_req_o    (rd_req_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_i   (rd_data_i),
    .rd_ack_i    (rd_ack_i),
    .wr_req_o    (wr_req_o),
    .wr_valid_o  (wr_valid_o),
    .wr_ack_i    (wr_ack_i),
    .load_data_o (load_data_o),
    .done_o      (done_o)
  );

  // untouched words hold a pattern built from every address bit
  function automatic logic [31:0] fill_word(input logic [29:0] widx);
    return {widx[21:0], widx[29:20]} ^ 32'h5a3c_c3a5;
  endfunction

  function automatic logic [31:0] bus_read(input logic [29:0] widx);
    if (bus_mem.exists(widx))
    begin
      return bus_mem[widx];
    end
    return fill_word(widx);
  endfunction

  function automatic logic [31:0] ref_read(input logic [29:0] widx);
    if (ref_mem.exists(widx))
    begin
      return ref_mem[widx];
    end
    return fill_word(widx);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
      begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [3:0] strobe_of(input lsu_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return 4'h1;
      OP_LH, OP_LHU, OP_SH: return 4'h3;
      default:              return 4'hf;
    endcase
  endfunction

  // shift down, keep the access size, then extend
  function automatic logic [31:0] expect_load(input lsu_op_e op, input logic [31:0] word,
                                              input logic [1:0] off);
    logic [31:0] sh;
    sh = word >> (8 * int'(off));
    case (op)
      OP_LB:   return {{24{sh[7]}}, sh[7:0]};
      OP_LBU:  return {24'h0, sh[7:0]};
      OP_LH:   return {{16{sh[15]}}, sh[15:0]};
      OP_LHU:  return {16'h0, sh[15:0]};
      default: return sh;
    endcase
  endfunction

  function automatic logic in_cache_range(input logic [31:0] a);
    return ((a >= `LSU_CACHE_R0_LO) && (a < `LSU_CACHE_R0_HI)) ||
           ((a >= `LSU_CACHE_R1_LO) && (a < `LSU_CACHE_R1_HI)) ||
           ((a >= `LSU_CACHE_R2_LO) && (a < `LSU_CACHE_R2_HI));
  endfunction

  // memory model, acks each request after one to three extra edges
  always @(posedge clk)
  begin
    rd_ack_i <= 1'b0;
    wr_ack_i <= 1'b0;
    if (!rst_n_i)
    begin
      mem_busy <= 1'b0;
    end
    else if ((rd_valid_o || wr_valid_o) && !rd_ack_i && !wr_ack_i)
    begin
      if (!mem_busy)
      begin
        mem_busy <= 1'b1;
        mem_wait <= 1 + (($random(seed) & 32'h7fff_ffff) % 3);
      end
      else if (mem_wait > 1)
      begin
        mem_wait <= mem_wait - 1;
      end
      else
      begin
        mem_busy <= 1'b0;
        if (rd_valid_o)
        begin
          rd_ack_i  <= 1'b1;
          rd_data_i <= bus_read(rd_req_o.addr[31:2]);
        end
        else
        begin
          wr_ack_i <= 1'b1;
          bus_mem[wr_req_o.addr[31:2]] = merge_bytes(bus_read(wr_req_o.addr[31:2]),
                                                     wr_req_o.data, wr_req_o.strb);
        end
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      error_count++;
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
      $display("Done: errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_idle(input string what);
    check_value({what, " rd_valid_o"}, 32'h0, {31'h0, rd_valid_o});
    check_value({what, " wr_valid_o"}, 32'h0, {31'h0, wr_valid_o});
    check_value({what, " done_o"}, 32'h0, {31'h0, done_o});
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n_i     <= 1'b0;
    req_valid_i <= 1'b0;
    issue_i     <= 1'b0;
    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      check_idle("during reset");
      @(posedge clk);
    end
    rst_n_i <= 1'b1;
  endtask

  // one request, held until done_o
  task automatic run_op(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                        output logic [31:0] data);
    @(posedge clk);
    req_i.op    <= op;
    req_i.addr  <= addr;
    req_i.wdata <= wdata;
    req_valid_i <= 1'b1;
    issue_i     <= 1'b1;
    saw_rd    = 1'b0;
    op_cycles = 0;
    @(negedge clk);
    first_rd_valid = rd_valid_o;
    first_wr_valid = wr_valid_o;
    seen_rd_strb   = rd_req_o.strb;
    seen_wr_strb   = wr_req_o.strb;
    seen_wr_data   = wr_req_o.data;
    while (!done_o)
    begin
      saw_rd = saw_rd | rd_valid_o;
      op_cycles++;
      @(posedge clk);
      issue_i <= 1'b0;
      @(negedge clk);
      if (rd_valid_o)
      begin
        check_value("held read address", addr, rd_req_o.addr);
      end
      if (wr_valid_o)
      begin
        check_value("held write address", addr, wr_req_o.addr);
      end
    end
    saw_rd = saw_rd | rd_valid_o;
    data   = load_data_o;
    @(posedge clk);
    issue_i     <= 1'b0;
    req_valid_i <= 1'b0;
    @(negedge clk);
    check_idle("idle");
  endtask

  task automatic do_store(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rsp;
    logic [3:0]  strb;
    strb = strobe_of(op);
    run_op(op, addr, wdata, rsp);
    check_value("write valid at issue", 32'h1, {31'h0, first_wr_valid});
    check_value("write strobe", {28'h0, strb}, {28'h0, seen_wr_strb});
    check_value("write data", wdata, seen_wr_data);
    check_value("read request on store", 32'h0, {31'h0, saw_rd});
    check_value("load data on store", 32'h0, rsp);
    ref_mem[addr[31:2]] = merge_bytes(ref_read(addr[31:2]), wdata, strb);
  endtask

  task automatic do_load(input lsu_op_e op, input logic [31:0] addr, input logic expect_hit);
    logic [31:0] rsp;
    logic [31:0] exp_data;
    exp_data = expect_load(op, ref_read(addr[31:2]), addr[1:0]);
    run_op(op, addr, 32'h0, rsp);
    check_value($sformatf("%s data at %h", op.name(), addr), exp_data, rsp);
    check_value($sformatf("read request at %h", addr), {31'h0, ~expect_hit}, {31'h0, saw_rd});
    if (expect_hit)
    begin
      check_value("hit latency in cycles", 32'h0, op_cycles);
    end
    else
    begin
      check_value("read valid at issue", 32'h1, {31'h0, first_rd_valid});
      check_value("read strobe", {28'h0, strobe_of(op)}, {28'h0, seen_rd_strb});
    end
  endtask

  task automatic test_store_strobes();
    test_name = "store_strobes";
    do_store(OP_SW, 32'h1000_0100, 32'hdead_beef);
    do_load(OP_LW, 32'h1000_0100, 1'b0);
    do_store(OP_SH, 32'h1000_0100, 32'h1234_5678);
    do_load(OP_LW, 32'h1000_0100, 1'b0);
    do_store(OP_SB, 32'h1000_0100, 32'h0000_00a5);
    do_load(OP_LW, 32'h1000_0100, 1'b0);
    do_store(OP_SB, 32'h1000_0104, 32'hffff_ff11);
    do_load(OP_LW, 32'h1000_0104, 1'b0);
  endtask

  task automatic test_load_align();
    lsu_op_e     kinds [5];
    logic [31:0] base;
    kinds = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    test_name = "load_align";
    do_store(OP_SW, 32'h2000_0040, 32'hf08c_a3e5);
    do_store(OP_SW, 32'h2000_0044, 32'h8f7e_9d81);
    for (int w = 0; w < 2; w++)
    begin
      base = 32'h2000_0040 + 32'(4 * w);
      for (int k = 0; k < 5; k++)
      begin
        for (int off = 0; off < 4; off++)
        begin
          do_load(kinds[k], base + 32'(off), 1'b0);
        end
      end
    end
  endtask

  task automatic test_cache_hit();
    logic [31:0] probes [7];
    probes = '{32'h3000_0000, 32'h2fff_fffc, 32'h4000_0000, 32'h803f_fffc,
               32'h8040_0000, 32'hbfff_fff0, 32'hc000_0000};
    test_name = "cache_hit";
    do_store(OP_SW, 32'h8000_0008, 32'hc0de_1234);
    do_load(OP_LW, 32'h8000_0008, 1'b0);
    do_load(OP_LW, 32'h8000_0008, 1'b1);
    do_load(OP_LBU, 32'h8000_0009, 1'b1);
    do_load(OP_LH, 32'h8000_000a, 1'b1);
    // range edges, a repeat hits only inside a window
    for (int p = 0; p < 7; p++)
    begin
      do_load(OP_LW, probes[p], 1'b0);
      do_load(OP_LW, probes[p], in_cache_range(probes[p]));
    end
  endtask

  task automatic test_store_inval();
    test_name = "store_inval";
    do_load(OP_LW, 32'ha000_000c, 1'b0);
    do_load(OP_LW, 32'ha000_000c, 1'b1);
    do_store(OP_SW, 32'ha000_000c, 32'h7e57_0a11);
    do_load(OP_LW, 32'ha000_000c, 1'b0);
    do_load(OP_LW, 32'ha000_000c, 1'b1);
    do_store(OP_SB, 32'ha000_000c, 32'h0000_003c);
    do_load(OP_LW, 32'ha000_000c, 1'b0);
  endtask

  task automatic test_conflict();
    logic [31:0] a;
    logic [31:0] b;
    test_name = "conflict";
    a = 32'h8000_0010;
    // same index, next tag up
    b = a + 32'(4 * `LSU_L1D_LINES);
    do_load(OP_LW, a, 1'b0);
    do_load(OP_LW, b, 1'b0);
    do_load(OP_LW, a, 1'b0);
    do_load(OP_LW, b, 1'b0);
    do_load(OP_LW, b, 1'b1);
  endtask

  task automatic test_after_reset();
    test_name = "after_reset";
    apply_reset();
    do_load(OP_LW, 32'h8000_0008, 1'b0);
    do_load(OP_LW, 32'h8000_0008, 1'b1);
    do_load(OP_LW, 32'h8000_0020, 1'b0);
    do_load(OP_LW, 32'ha000_000c, 1'b0);
  endtask

  initial
  begin
    rst_n_i     = 1'b0;
    issue_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    apply_reset();
    test_store_strobes();
    test_load_align();
    test_cache_hit();
    test_store_inval();
    test_conflict();
    test_after_reset();
    if (error_count == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- lsu_top.f
+incdir+common
common/lsu_op_pkg.sv
common/lsu_bus_pkg.sv
lsu/lsu_op_decode.sv
lsu/lsu_access_ctrl.sv
lsu/lsu_l1d_cache.sv
lsu/lsu_load_align.sv
lsu/lsu_top.sv
testbench/lsu_tb.sv

//--- Makefile
# Verilator simulation of the load/store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
